//--- tileVideo_params.svh
// tiles are square (TV_TILE_W lines high), TV_PIX_DIV >= 2, TV_CREDITS a power of two
`ifndef TILEVIDEO_PARAMS_SVH
`define TILEVIDEO_PARAMS_SVH

// ==============================
// horizontal timing, in pixels
`define TV_H_ACTIVE    64
`define TV_H_TOTAL     96
`define TV_HSYNC_START 72
`define TV_HSYNC_END   80

// ==============================
// vertical timing, in lines
`define TV_V_ACTIVE    16
`define TV_V_TOTAL     20
`define TV_VSYNC_LINE  17

// ==============================
// tiles, clocking and host path
`define TV_TILE_W      8
`define TV_COLS        8
`define TV_PIX_DIV     2
`define TV_RAM_WORDS   16
// credits held by the host, same as the command FIFO depth
`define TV_CREDITS     4

`endif

//--- videoPkg.sv
// counter and RAM widths are fixed here and must cover the ranges in tileVideo_params.svh
package videoPkg;

   // pixel and line counters
   typedef logic [6:0] hCount_t;
   typedef logic [4:0] vCount_t;

   // tile RAM
   typedef logic [3:0] ramAddr_t;
   typedef logic [7:0] ramData_t;

   // last grant given by the arbiter
   typedef enum logic [1:0] {ARB_IDLE, ARB_READ, ARB_WRITE} arbState_t;

endpackage

//--- hostPkg.sv
// credit_t must hold the value TV_CREDITS itself, not only TV_CREDITS - 1
package hostPkg;

   // host commands
   typedef enum logic
   {
      OP_WRITE_TILE = 1'b0,
      OP_SET_FLIP   = 1'b1
   } hostOp_t;

   // commands held in the queue, 0 up to TV_CREDITS
   typedef logic [2:0] credit_t;

endpackage

//--- videoTiming.sv
// counters come out of reset at the last pixel of the frame, so blank_o starts high
`timescale 1ns/1ps
`include "tileVideo_params.svh"

module videoTiming
(
   input  logic              clk,
   input  logic              CR,
   output logic              pixEn_o,
   output videoPkg::hCount_t hCount_o,
   output videoPkg::vCount_t vCount_o,
   output logic              hsync_o,
   output logic              vsync_o,
   output logic              blank_o
);

   localparam int divWidth = $clog2(`TV_PIX_DIV);
   localparam logic [divWidth-1:0] divLast = divWidth'(`TV_PIX_DIV - 1);

   logic [divWidth-1:0] divCnt;
   videoPkg::hCount_t   hNext;
   videoPkg::vCount_t   vNext;

   // pixel enable divider
   assign pixEn_o = (divCnt == divLast);

   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
         divCnt <= '0;
      else if (pixEn_o)
         divCnt <= '0;
      else
         divCnt <= divCnt + 1'b1;
   end

   // next position, line wraps into the next frame line
   always_comb
   begin
      hNext = hCount_o + 1'b1;
      vNext = vCount_o;
      if (hCount_o == videoPkg::hCount_t'(`TV_H_TOTAL - 1))
      begin
         hNext = '0;
         if (vCount_o == videoPkg::vCount_t'(`TV_V_TOTAL - 1))
            vNext = '0;
         else
            vNext = vCount_o + 1'b1;
      end
   end

   // sync and blank decoded from the next position, so they line up with the counters
   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
      begin
         hCount_o <= videoPkg::hCount_t'(`TV_H_TOTAL - 1);
         vCount_o <= videoPkg::vCount_t'(`TV_V_TOTAL - 1);
         hsync_o  <= 1'b0;
         vsync_o  <= 1'b0;
         blank_o  <= 1'b1;
      end
      else if (pixEn_o)
      begin
         hCount_o <= hNext;
         vCount_o <= vNext;
         hsync_o  <= (hNext >= videoPkg::hCount_t'(`TV_HSYNC_START)) &&
                     (hNext < videoPkg::hCount_t'(`TV_HSYNC_END));
         vsync_o  <= (vNext == videoPkg::vCount_t'(`TV_VSYNC_LINE));
         blank_o  <= (hNext >= videoPkg::hCount_t'(`TV_H_ACTIVE)) ||
                     (vNext >= videoPkg::vCount_t'(`TV_V_ACTIVE));
      end
   end

endmodule

//--- hostWriteQueue.sv
// the host must hold a credit for every hostValid_i, since a push into a full FIFO is not caught
`timescale 1ns/1ps
`include "tileVideo_params.svh"

module hostWriteQueue
(
   input  logic               clk,
   input  logic               CR,
   input  logic               hostValid_i,
   input  hostPkg::hostOp_t   hostOp_i,
   input  videoPkg::ramAddr_t hostAddr_i,
   input  videoPkg::ramData_t hostData_i,
   input  logic               wrDone_i,
   output logic               wrReq_o,
   output videoPkg::ramAddr_t wrAddr_o,
   output videoPkg::ramData_t wrData_o,
   output logic               flip_o,
   output logic               hostCredit_o
);

   localparam int ptrWidth = $clog2(`TV_CREDITS);

   hostPkg::hostOp_t    fifoOp   [`TV_CREDITS];
   videoPkg::ramAddr_t  fifoAddr [`TV_CREDITS];
   videoPkg::ramData_t  fifoData [`TV_CREDITS];
   logic [ptrWidth-1:0] wrPtr;
   logic [ptrWidth-1:0] rdPtr;
   hostPkg::credit_t    count;
   logic                headValid;
   logic                headIsFlip;
   logic                popWrite;
   logic                popFlip;
   logic                flipCredit;

   // ==============================
   // head of the queue
   assign headValid  = (count != '0);
   assign headIsFlip = (fifoOp[rdPtr] == hostPkg::OP_SET_FLIP);
   // head stays put while a write is pending
   assign wrAddr_o   = fifoAddr[rdPtr];
   assign wrData_o   = fifoData[rdPtr];

   assign popWrite = wrReq_o && wrDone_i;
   assign popFlip  = headValid && headIsFlip && !wrReq_o;

   // write credit comes back with wrDone, flip credit one cycle after the head
   assign hostCredit_o = popWrite | flipCredit;

   always_ff @(posedge clk)
   begin
      if (hostValid_i)
      begin
         fifoOp[wrPtr]   <= hostOp_i;
         fifoAddr[wrPtr] <= hostAddr_i;
         fifoData[wrPtr] <= hostData_i;
      end
   end

   // ==============================
   // pointers, write request and flip register
   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
      begin
         wrPtr      <= '0;
         rdPtr      <= '0;
         count      <= '0;
         wrReq_o    <= 1'b0;
         flip_o     <= 1'b0;
         flipCredit <= 1'b0;
      end
      else
      begin
         if (hostValid_i)
            wrPtr <= wrPtr + 1'b1;
         if (popWrite || popFlip)
            rdPtr <= rdPtr + 1'b1;
         count <= count + hostPkg::credit_t'(hostValid_i) -
                  hostPkg::credit_t'(popWrite || popFlip);

         if (popWrite)
            wrReq_o <= 1'b0;
         else if (headValid && !headIsFlip && !wrReq_o)
            wrReq_o <= 1'b1;

         if (popFlip)
            flip_o <= fifoData[rdPtr][0];
         flipCredit <= popFlip;
      end
   end

endmodule

//--- tileRamArbiter.sv
// reads always win; a write waits for a free cycle and cannot be granted twice in a row
`timescale 1ns/1ps
`include "tileVideo_params.svh"

module tileRamArbiter
(
   input  logic               clk,
   input  logic               CR,
   input  logic               rdReq_i,
   input  videoPkg::ramAddr_t rdAddr_i,
   output videoPkg::ramData_t rdData_o,
   input  logic               wrReq_i,
   input  videoPkg::ramAddr_t wrAddr_i,
   input  videoPkg::ramData_t wrData_i,
   output logic               wrDone_o
);

   videoPkg::ramData_t  ram [`TV_RAM_WORDS];
   videoPkg::arbState_t state;
   logic                grantWr;

   // ==============================
   // fixed priority grant
   // no write grant while the previous write's done is still showing
   assign grantWr  = wrReq_i && !rdReq_i && (state != videoPkg::ARB_WRITE);
   assign wrDone_o = (state == videoPkg::ARB_WRITE);

   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
         state <= videoPkg::ARB_IDLE;
      else if (rdReq_i)
         state <= videoPkg::ARB_READ;
      else if (grantWr)
         state <= videoPkg::ARB_WRITE;
      else
         state <= videoPkg::ARB_IDLE;
   end

   // ==============================
   // tile RAM, one port shared by both sides
   always_ff @(posedge clk)
   begin
      if (rdReq_i)
         rdData_o <= ram[rdAddr_i];
      if (grantWr)
         ram[wrAddr_i] <= wrData_i;
   end

endmodule

//--- tileSerializer.sv
// pixel, blank and sync outputs lag the timing counters by one pixel; flip is sampled per tile
`timescale 1ns/1ps
`include "tileVideo_params.svh"

module tileSerializer
(
   input  logic               clk,
   input  logic               CR,
   input  logic               pixEn_i,
   input  videoPkg::hCount_t  hCount_i,
   input  videoPkg::vCount_t  vCount_i,
   input  logic               hsync_i,
   input  logic               vsync_i,
   input  logic               blank_i,
   input  logic               flip_i,
   output logic               rdReq_o,
   output videoPkg::ramAddr_t rdAddr_o,
   input  videoPkg::ramData_t rdData_i,
   output logic               pixel_o,
   output logic               blank_o,
   output logic               hsync_o,
   output logic               vsync_o
);

   videoPkg::hCount_t  tileIdx;
   videoPkg::hCount_t  fetchCol;
   videoPkg::vCount_t  fetchLine;
   logic               boundary;
   logic               leadIn;
   logic               fetchNow;
   logic               rdWait;
   logic               flipTile;
   videoPkg::ramData_t tileBuf;
   videoPkg::ramData_t shiftReg;

   // ==============================
   // fetch side
   assign tileIdx  = hCount_i / videoPkg::hCount_t'(`TV_TILE_W);
   assign boundary = ((hCount_i % videoPkg::hCount_t'(`TV_TILE_W)) == '0);
   // last tile slot of the line, used to fetch column 0 of the next line
   assign leadIn   = (hCount_i == videoPkg::hCount_t'(`TV_H_TOTAL - `TV_TILE_W));

   always_comb
   begin
      fetchLine = vCount_i;
      fetchCol  = tileIdx + 1'b1;
      if (leadIn)
      begin
         fetchCol = '0;
         if (vCount_i == videoPkg::vCount_t'(`TV_V_TOTAL - 1))
            fetchLine = '0;
         else
            fetchLine = vCount_i + 1'b1;
      end
      fetchNow = pixEn_i && boundary &&
                 (fetchCol < videoPkg::hCount_t'(`TV_COLS)) &&
                 (fetchLine < videoPkg::vCount_t'(`TV_V_ACTIVE));
   end

   always_ff @(posedge clk)
   begin
      if (fetchNow)
         rdAddr_o <= videoPkg::ramAddr_t'((fetchLine / `TV_TILE_W) * `TV_COLS + fetchCol);
   end

   // tileBuf is cleared at each boundary, so slots without a fetch show zero
   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
      begin
         rdReq_o <= 1'b0;
         rdWait  <= 1'b0;
         tileBuf <= '0;
      end
      else
      begin
         rdReq_o <= fetchNow;
         rdWait  <= rdReq_o;
         if (rdWait)
            tileBuf <= rdData_i;
         else if (pixEn_i && boundary)
            tileBuf <= '0;
      end
   end

   // ==============================
   // shift register, MSB first normally, LSB first when flipped
   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
      begin
         shiftReg <= '0;
         flipTile <= 1'b0;
         blank_o  <= 1'b1;
         hsync_o  <= 1'b0;
         vsync_o  <= 1'b0;
      end
      else if (pixEn_i)
      begin
         // timing delayed by one pixel, same as the load below
         blank_o <= blank_i;
         hsync_o <= hsync_i;
         vsync_o <= vsync_i;
         if (boundary)
         begin
            shiftReg <= tileBuf;
            flipTile <= flip_i;
         end
         else if (flipTile)
            shiftReg <= {1'b0, shiftReg[7:1]};
         else
            shiftReg <= {shiftReg[6:0], 1'b0};
      end
   end

   assign pixel_o = flipTile ? shiftReg[0] : shiftReg[7];

endmodule

//--- tileVideoTop.sv
// hostValid_i must only be raised while the host holds a credit, there is no other back-pressure
`timescale 1ns/1ps

module tileVideoTop
(
   input  logic               clk,
   input  logic               CR,
   input  logic               hostValid_i,
   input  hostPkg::hostOp_t   hostOp_i,
   input  videoPkg::ramAddr_t hostAddr_i,
   input  videoPkg::ramData_t hostData_i,
   output logic               hostCredit_o,
   output logic               pixel_o,
   output logic               blank_o,
   output logic               hsync_o,
   output logic               vsync_o
);

   // ==============================
   // timing to serializer
   logic               pixEn;
   videoPkg::hCount_t  hCount;
   videoPkg::vCount_t  vCount;
   logic               tHsync;
   logic               tVsync;
   logic               tBlank;

   // host queue and serializer to arbiter
   logic               wrReq;
   videoPkg::ramAddr_t wrAddr;
   videoPkg::ramData_t wrData;
   logic               wrDone;
   logic               flip;
   logic               rdReq;
   videoPkg::ramAddr_t rdAddr;
   videoPkg::ramData_t rdData;

   videoTiming uTiming
   (
      .clk      (clk),
      .CR       (CR),
      .pixEn_o  (pixEn),
      .hCount_o (hCount),
      .vCount_o (vCount),
      .hsync_o  (tHsync),
      .vsync_o  (tVsync),
      .blank_o  (tBlank)
   );

   hostWriteQueue uQueue
   (
      .clk          (clk),
      .CR           (CR),
      .hostValid_i  (hostValid_i),
      .hostOp_i     (hostOp_i),
      .hostAddr_i   (hostAddr_i),
      .hostData_i   (hostData_i),
      .wrDone_i     (wrDone),
      .wrReq_o      (wrReq),
      .wrAddr_o     (wrAddr),
      .wrData_o     (wrData),
      .flip_o       (flip),
      .hostCredit_o (hostCredit_o)
   );

   tileRamArbiter uArbiter
   (
      .clk      (clk),
      .CR       (CR),
      .rdReq_i  (rdReq),
      .rdAddr_i (rdAddr),
      .rdData_o (rdData),
      .wrReq_i  (wrReq),
      .wrAddr_i (wrAddr),
      .wrData_i (wrData),
      .wrDone_o (wrDone)
   );

   tileSerializer uSerializer
   (
      .clk      (clk),
      .CR       (CR),
      .pixEn_i  (pixEn),
      .hCount_i (hCount),
      .vCount_i (vCount),
      .hsync_i  (tHsync),
      .vsync_i  (tVsync),
      .blank_i  (tBlank),
      .flip_i   (flip),
      .rdReq_o  (rdReq),
      .rdAddr_o (rdAddr),
      .rdData_i (rdData),
      .pixel_o  (pixel_o),
      .blank_o  (blank_o),
      .hsync_o  (hsync_o),
      .vsync_o  (vsync_o)
   );

endmodule

//--- tileVideo_properties.sv
// the credit bound assumes the host starts with TV_CREDITS credits after every reset
`timescale 1ns/1ps
`include "tileVideo_params.svh"

module tileVideoProperties
(
   input logic clk,
   input logic CR,
   input logic hostValid_i,
   input logic hostCredit_i,
   input logic hsync_i,
   input logic vsync_i,
   input logic blank_i
);

   int failCount = 0;
   int outstanding;

   // commands not yet credited back
   always @(posedge clk or negedge CR)
   begin
      if (!CR)
         outstanding <= 0;
      else
         outstanding <= outstanding + int'(hostValid_i) - int'(hostCredit_i);
   end

   // ==============================
   // credits
   sendNeedsCredit: assert property (@(posedge clk) disable iff (!CR)
      hostValid_i |-> outstanding < `TV_CREDITS)
   else
   begin
      $error("command accepted while the host held no credit");
      failCount++;
   end

   creditNeedsCommand: assert property (@(posedge clk) disable iff (!CR)
      hostCredit_i |-> outstanding > 0)
   else
   begin
      $error("credit returned with no command outstanding");
      failCount++;
   end

   // ==============================
   // sync
   vsyncInBlank: assert property (@(posedge clk) disable iff (!CR)
      vsync_i |-> blank_i)
   else
   begin
      $error("vsync_o high outside blanking");
      failCount++;
   end

   vsyncRiseOffHsync: assert property (@(posedge clk) disable iff (!CR)
      $rose(vsync_i) |-> !hsync_i)
   else
   begin
      $error("vsync_o rose during an hsync_o pulse");
      failCount++;
   end

endmodule

//--- tileVideoChecker.sv
// checks pixels only in frames that start with no command outstanding and see none arrive
`timescale 1ns/1ps
`include "tileVideo_params.svh"

module tileVideoChecker
(
   input  logic               clk,
   input  logic               CR,
   input  logic               hostValid_i,
   input  hostPkg::hostOp_t   hostOp_i,
   input  videoPkg::ramAddr_t hostAddr_i,
   input  videoPkg::ramData_t hostData_i,
   input  logic               hostCredit_i,
   input  logic               pixel_i,
   input  logic               blank_i,
   input  logic               hsync_i,
   input  logic               vsync_i,
   output int                 errCount_o,
   output int                 framesChecked_o,
   output int                 creditsSeen_o
);

   localparam int lineClocks = `TV_H_ACTIVE * `TV_PIX_DIV;
   localparam int syncClocks = `TV_H_TOTAL * `TV_PIX_DIV;

   videoPkg::ramData_t ramModel [`TV_RAM_WORDS];
   logic flipModel   = 1'b0;
   logic inReset     = 1'b0;
   logic frameOk     = 1'b0;
   logic vsyncSeen   = 1'b0;
   logic prevHsync   = 1'b0;
   logic prevVsync   = 1'b0;
   int   outstanding = 0;
   int   lowClocks   = 0;
   int   lineCnt     = 0;
   int   hsyncCnt    = 0;
   int   vsyncClocks = 0;
   int   xPos;
   int   byteIdx;
   logic expPixel;

   initial
   begin
      errCount_o      = 0;
      framesChecked_o = 0;
      creditsSeen_o   = 0;
      for (int i = 0; i < `TV_RAM_WORDS; i++)
         ramModel[i] = '0;
   end

   task automatic checkValue(input string name, input int expVal, input int actVal);
   begin
      if (expVal != actVal)
      begin
         $display("[ERROR] %0t %s expected %0d actual %0d", $time, name, expVal, actVal);
         errCount_o++;
      end
   end
   endtask

   always @(posedge clk)
   begin
      if (!CR)
      begin
         // skip the first edge, reset values show after it
         if (inReset)
         begin
            checkValue("hostCredit_o", 0, hostCredit_i);
            checkValue("pixel_o", 0, pixel_i);
            checkValue("hsync_o", 0, hsync_i);
            checkValue("vsync_o", 0, vsync_i);
            checkValue("blank_o", 1, blank_i);
         end
         inReset = 1'b1;
      end
      else
      begin
         inReset = 1'b0;

         // ==============================
         // frame and sync bookkeeping
         if (hsync_i && !prevHsync)
            hsyncCnt++;
         if (vsync_i)
            vsyncClocks++;
         else if (prevVsync)
         begin
            checkValue("vsync_o high clocks", syncClocks, vsyncClocks);
            vsyncClocks = 0;
         end
         if (vsync_i && !prevVsync)
         begin
            if (vsyncSeen)
               checkValue("hsync_o pulses per frame", `TV_V_TOTAL, hsyncCnt);
            if (frameOk)
            begin
               checkValue("visible lines per frame", `TV_V_ACTIVE, lineCnt);
               framesChecked_o++;
            end
            vsyncSeen = 1'b1;
            hsyncCnt  = 0;
            lineCnt   = 0;
            frameOk   = (outstanding == 0);
         end
         prevHsync = hsync_i;
         prevVsync = vsync_i;

         // ==============================
         // pixels and line length
         if (!blank_i)
         begin
            xPos = lowClocks / `TV_PIX_DIV;
            if (frameOk && xPos < `TV_H_ACTIVE && lineCnt < `TV_V_ACTIVE)
            begin
               byteIdx = (lineCnt / `TV_TILE_W) * `TV_COLS + xPos / `TV_TILE_W;
               if (flipModel)
                  expPixel = ramModel[byteIdx][xPos % `TV_TILE_W];
               else
                  expPixel = ramModel[byteIdx][`TV_TILE_W - 1 - xPos % `TV_TILE_W];
               if (pixel_i !== expPixel)
               begin
                  $display("[ERROR] %0t pixel_o expected %0b actual %0b",
                           $time, expPixel, pixel_i);
                  errCount_o++;
               end
            end
            lowClocks++;
         end
         else if (lowClocks != 0)
         begin
            checkValue("blank_o low clocks", lineClocks, lowClocks);
            lowClocks = 0;
            lineCnt++;
         end

         // ==============================
         // credits and the RAM and flip models
         if (hostCredit_i)
         begin
            if (outstanding == 0)
            begin
               $display("a credit came back while no command was outstanding");
               errCount_o++;
            end
            creditsSeen_o++;
         end
         if (hostValid_i)
         begin
            if (outstanding >= `TV_CREDITS)
            begin
               $display("a command was sent while the host held no credit");
               errCount_o++;
            end
            if (hostOp_i == hostPkg::OP_WRITE_TILE)
               ramModel[hostAddr_i] = hostData_i;
            else
               flipModel = hostData_i[0];
            // the frame in flight no longer matches the model
            frameOk = 1'b0;
         end
         outstanding = outstanding + int'(hostValid_i) - int'(hostCredit_i);
      end
   end

endmodule

//--- tb_tileVideo.sv
// all tile addresses are written before the first checked frame; the run ends at a cycle limit
`timescale 1ns/1ps
`include "tileVideo_params.svh"

module tb_tileVideo;

   localparam int numCmds    = `TV_RAM_WORDS + 2;
   localparam int cycleLimit = (numCmds + 4) * `TV_H_TOTAL * `TV_V_TOTAL * `TV_PIX_DIV;

   logic               clk;
   logic               CR;
   logic               hostValid;
   hostPkg::hostOp_t   hostOp;
   videoPkg::ramAddr_t hostAddr;
   videoPkg::ramData_t hostData;
   logic               hostCredit;
   logic               pixel;
   logic               blank;
   logic               hsync;
   logic               vsync;

   // command table, one row per host command
   hostPkg::hostOp_t   tblOp   [numCmds];
   videoPkg::ramAddr_t tblAddr [numCmds];
   videoPkg::ramData_t tblData [numCmds];

   integer seed;
   int     credits  = `TV_CREDITS;
   int     tbErrors = 0;
   int     sent     = 0;
   int     cycles   = 0;
   int     chkErrors;
   int     framesChecked;
   int     creditsSeen;
   int     assertErrors;

   tileVideoTop dut
   (
      .clk          (clk),
      .CR           (CR),
      .hostValid_i  (hostValid),
      .hostOp_i     (hostOp),
      .hostAddr_i   (hostAddr),
      .hostData_i   (hostData),
      .hostCredit_o (hostCredit),
      .pixel_o      (pixel),
      .blank_o      (blank),
      .hsync_o      (hsync),
      .vsync_o      (vsync)
   );

   tileVideoChecker uCheck
   (
      .clk             (clk),
      .CR              (CR),
      .hostValid_i     (hostValid),
      .hostOp_i        (hostOp),
      .hostAddr_i      (hostAddr),
      .hostData_i      (hostData),
      .hostCredit_i    (hostCredit),
      .pixel_i         (pixel),
      .blank_i         (blank),
      .hsync_i         (hsync),
      .vsync_i         (vsync),
      .errCount_o      (chkErrors),
      .framesChecked_o (framesChecked),
      .creditsSeen_o   (creditsSeen)
   );

   bind tileVideoTop tileVideoProperties uProps
   (
      .clk          (clk),
      .CR           (CR),
      .hostValid_i  (hostValid_i),
      .hostCredit_i (hostCredit_o),
      .hsync_i      (hsync_o),
      .vsync_i      (vsync_o),
      .blank_i      (blank_o)
   );

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // host side credit count
   always @(posedge clk)
   begin
      if (!CR)
         credits <= `TV_CREDITS;
      else
      begin
         if (credits < 0 || credits > `TV_CREDITS)
         begin
            $display("the host credit count left its range, it is now %0d", credits);
            tbErrors++;
         end
         credits <= credits + int'(hostCredit) - int'(hostValid);
      end
   end

   initial
   begin
      while (cycles < cycleLimit)
      begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout after %0d cycles, the run did not reach its end", cycles);
      $display("Test failed");
      $finish;
   end

   // all credits back, then one whole frame in the new state
   task automatic settleFrames();
   begin
      while (credits != `TV_CREDITS)
         @(negedge clk);
      repeat (2) @(posedge vsync);
      repeat (2) @(negedge clk);
   end
   endtask

   initial
   begin
      int i;
      seed      = 19;
      CR        = 1'b0;
      hostValid = 1'b0;
      hostOp    = hostPkg::OP_WRITE_TILE;
      hostAddr  = '0;
      hostData  = '0;

      // ==============================
      // one write per address, every fourth from $random
      for (i = 0; i < `TV_RAM_WORDS; i++)
      begin
         tblOp[i]   = hostPkg::OP_WRITE_TILE;
         tblAddr[i] = videoPkg::ramAddr_t'(i);
         if (i % 4 == 1)
            tblData[i] = videoPkg::ramData_t'($random(seed));
         else
            tblData[i] = {tblAddr[i], ~tblAddr[i]};
      end
      // flip on, then back off
      tblOp[numCmds-2]   = hostPkg::OP_SET_FLIP;
      tblAddr[numCmds-2] = '0;
      tblData[numCmds-2] = 8'h01;
      tblOp[numCmds-1]   = hostPkg::OP_SET_FLIP;
      tblAddr[numCmds-1] = '0;
      tblData[numCmds-1] = 8'h00;

      repeat (4) @(negedge clk);
      CR = 1'b1;

      for (i = 0; i < numCmds; i++)
      begin
         while (credits == 0)
            @(negedge clk);
         hostValid = 1'b1;
         hostOp    = tblOp[i];
         hostAddr  = tblAddr[i];
         hostData  = tblData[i];
         sent++;
         @(negedge clk);
         hostValid = 1'b0;
         if (tblOp[i] == hostPkg::OP_SET_FLIP)
            settleFrames();
      end

      // ==============================
      // closing checks
      assertErrors = dut.uProps.failCount;
      if (creditsSeen != sent)
      begin
         $display("[ERROR] %0t hostCredit_o pulses expected %0d actual %0d",
                  $time, sent, creditsSeen);
         tbErrors++;
      end
      if (framesChecked < 2)
      begin
         $display("only %0d frames were checked, at least 2 were expected", framesChecked);
         tbErrors++;
      end
      $display("errors: testbench %0d, checker %0d, assertions %0d",
               tbErrors, chkErrors, assertErrors);
      if (tbErrors + chkErrors + assertErrors == 0)
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   end

endmodule

//--- project.f
+incdir+.
videoPkg.sv
hostPkg.sv
videoTiming.sv
hostWriteQueue.sv
tileRamArbiter.sv
tileSerializer.sv
tileVideoTop.sv
tileVideo_properties.sv
tileVideoChecker.sv
tb_tileVideo.sv

//--- run.sh
#!/bin/sh
# compile with Verilator, run, and decide pass or fail from the log
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_tileVideo -f project.f
./obj_dir/Vtb_tileVideo | tee sim.log
grep -q "^Test passed$" sim.log
echo "simulation passed"
